//--- l1_dcache_top.f
common/l1_cache_pkg.sv
design/tag_state_array.sv
design/data_array.sv
design/lookup_stage.sv
design/line_ctrl_stage.sv
design/l1_dcache_top.sv
testbench/tb_clock_gen.sv
testbench/lv2_memory_model.sv
testbench/l1_dcache_checker.sv
testbench/l1_dcache_tb.sv

//--- testbench/l1_dcache_tb.sv
// L1 data cache testbench top: stimulus table, driving loop, instances and report
`timescale 1ns/1ns
`default_nettype none

module l1_dcache_tb;
    import l1_cache_pkg::*;

    localparam int NUM_ROWS = 16;
    localparam int TIMEOUT  = 200;

    logic              clk;
    logic              arst_n;
    logic              cpu_valid;
    logic              cpu_ready;
    cpu_op_e           cpu_op;
    logic [ADDR_W-1:0] cpu_addr;
    data_t             cpu_wdata;
    logic              rsp_valid;
    data_t             rsp_rdata;
    logic              lv2_req_valid;
    logic              lv2_req_ready;
    lv2_op_e           lv2_req_op;
    logic [ADDR_W-1:0] lv2_addr;
    data_t             lv2_wdata;
    logic              lv2_rsp_valid;
    data_t             lv2_rsp_rdata;

    // stimulus and expected values, one row per request
    cpu_op_e     row_op      [NUM_ROWS];
    logic [31:0] row_addr    [NUM_ROWS];
    logic [31:0] row_wdata   [NUM_ROWS];
    logic [31:0] row_rdata   [NUM_ROWS];
    bit          row_fill    [NUM_ROWS];
    bit          row_wb      [NUM_ROWS];
    logic [31:0] row_wb_addr [NUM_ROWS];
    logic [31:0] row_wb_data [NUM_ROWS];

    logic [31:0] gap_lfsr   = 32'h85c8;

    tb_clock_gen u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    l1_dcache_top u_dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .cpu_valid     (cpu_valid),
        .cpu_ready     (cpu_ready),
        .cpu_op        (cpu_op),
        .cpu_addr      (cpu_addr),
        .cpu_wdata     (cpu_wdata),
        .rsp_valid     (rsp_valid),
        .rsp_rdata     (rsp_rdata),
        .lv2_req_valid (lv2_req_valid),
        .lv2_req_ready (lv2_req_ready),
        .lv2_req_op    (lv2_req_op),
        .lv2_addr      (lv2_addr),
        .lv2_wdata     (lv2_wdata),
        .lv2_rsp_valid (lv2_rsp_valid),
        .lv2_rsp_rdata (lv2_rsp_rdata)
    );

    lv2_memory_model u_mem (
        .clk           (clk),
        .arst_n        (arst_n),
        .lv2_req_valid (lv2_req_valid),
        .lv2_req_ready (lv2_req_ready),
        .lv2_req_op    (lv2_req_op),
        .lv2_addr      (lv2_addr),
        .lv2_wdata     (lv2_wdata),
        .lv2_rsp_valid (lv2_rsp_valid),
        .lv2_rsp_rdata (lv2_rsp_rdata)
    );

    l1_dcache_checker u_checker (
        .clk           (clk),
        .arst_n        (arst_n),
        .cpu_valid     (cpu_valid),
        .cpu_ready     (cpu_ready),
        .rsp_valid     (rsp_valid),
        .rsp_rdata     (rsp_rdata),
        .lv2_req_valid (lv2_req_valid),
        .lv2_req_ready (lv2_req_ready),
        .lv2_req_op    (lv2_req_op),
        .lv2_addr      (lv2_addr),
        .lv2_wdata     (lv2_wdata)
    );

    // galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] stepped;
        stepped = state >> 1;
        if (state[0]) begin
            stepped = stepped ^ 32'h8020_0003;
        end
        return stepped;
    endfunction

    task automatic set_row(input int i, input cpu_op_e op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] rdata,
                           input bit fill, input bit wb, input logic [31:0] wb_addr,
                           input logic [31:0] wb_data);
        row_op[i]      = op;
        row_addr[i]    = addr;
        row_wdata[i]   = wdata;
        row_rdata[i]   = rdata;
        row_fill[i]    = fill;
        row_wb[i]      = wb;
        row_wb_addr[i] = wb_addr;
        row_wb_data[i] = wb_data;
    endtask

    // ==================================================
    // table, reads of fresh lines return addr ^ 5a5a0000
    // ==================================================
    task automatic fill_table();
        set_row(0,  op_read,  32'h100, 0, 32'h5a5a0100, 1, 0, 0, 0);
        set_row(1,  op_read,  32'h100, 0, 32'h5a5a0100, 0, 0, 0, 0);
        set_row(2,  op_write, 32'h100, 32'h11110000, 0, 0, 0, 0, 0);
        set_row(3,  op_read,  32'h100, 0, 32'h11110000, 0, 0, 0, 0);
        set_row(4,  op_write, 32'h208, 32'h22220000, 0, 1, 0, 0, 0);
        set_row(5,  op_read,  32'h208, 0, 32'h22220000, 0, 0, 0, 0);
        // set 1, three tags, the modified way is evicted
        set_row(6,  op_write, 32'h004, 32'h33330000, 0, 1, 0, 0, 0);
        set_row(7,  op_read,  32'h044, 0, 32'h5a5a0044, 1, 0, 0, 0);
        set_row(8,  op_read,  32'h084, 0, 32'h5a5a0084, 1, 1, 32'h004, 32'h33330000);
        set_row(9,  op_read,  32'h004, 0, 32'h33330000, 1, 0, 0, 0);
        set_row(10, op_read,  32'h084, 0, 32'h5a5a0084, 0, 0, 0, 0);
        // set 0 churn with two dirty victims
        set_row(11, op_write, 32'h3c0, 32'h44440000, 0, 1, 0, 0, 0);
        set_row(12, op_read,  32'h500, 0, 32'h5a5a0500, 1, 1, 32'h100, 32'h11110000);
        set_row(13, op_read,  32'h100, 0, 32'h11110000, 1, 1, 32'h3c0, 32'h44440000);
        set_row(14, op_read,  32'h3c0, 0, 32'h44440000, 1, 0, 0, 0);
        set_row(15, op_read,  32'h208, 0, 32'h22220000, 0, 0, 0, 0);
    endtask

    initial begin
        bit accepted;
        bit b0;
        bit b1;
        int waited;
        cpu_valid     = 1'b0;
        cpu_op        = op_read;
        cpu_addr      = '0;
        cpu_wdata     = '0;
        fill_table();
        waited = 0;
        while (arst_n !== 1'b1) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout waiting for reset release");
                $display("Test failed");
                $finish;
            end
        end
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            b0       = gap_lfsr[0];
            gap_lfsr = lfsr_step(gap_lfsr);
            b1       = gap_lfsr[0];
            gap_lfsr = lfsr_step(gap_lfsr);
            repeat ({b1, b0}) begin
                @(posedge clk);
                #1;
            end
            // hits start from an empty pipe so their latency is checked
            waited = 0;
            while (!row_fill[i] && u_checker.rsp_count < i) begin
                @(posedge clk);
                #1;
                waited++;
                if (waited > TIMEOUT) begin
                    $display("timeout waiting for the pipe to drain before request %0d", i);
                    $display("Test failed");
                    $finish;
                end
            end
            cpu_valid = 1'b1;
            cpu_op    = row_op[i];
            cpu_addr  = row_addr[i];
            cpu_wdata = row_wdata[i];
            accepted  = 1'b0;
            waited    = 0;
            while (!accepted) begin
                @(negedge clk);
                accepted = cpu_ready;
                @(posedge clk);
                #1;
                waited++;
                if (waited > TIMEOUT) begin
                    $display("timeout waiting for cpu_ready on request %0d", i);
                    $display("Test failed");
                    $finish;
                end
            end
            cpu_valid = 1'b0;
        end
        waited = 0;
        while (u_checker.rsp_count < NUM_ROWS) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("missing response, only %0d of %0d arrived",
                         u_checker.rsp_count, NUM_ROWS);
                $display("Test failed");
                $finish;
            end
        end
        // catch stray traffic after the last response
        repeat (10) @(posedge clk);
        $display("errors: %0d, responses: %0d of %0d",
                 u_checker.error_count, u_checker.rsp_count, NUM_ROWS);
        if (u_checker.error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/l1_dcache_checker.sv
// checker: reset values, response data, hit latency and level 2 traffic per request
`timescale 1ns/1ns
`default_nettype none

module l1_dcache_checker
    import l1_cache_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    arst_n,
    input  wire logic    cpu_valid,
    input  wire logic    cpu_ready,
    input  wire logic    rsp_valid,
    input  wire data_t   rsp_rdata,
    input  wire logic    lv2_req_valid,
    input  wire logic    lv2_req_ready,
    input  wire lv2_op_e lv2_req_op,
    input  wire logic [ADDR_W-1:0] lv2_addr,
    input  wire data_t   lv2_wdata
);

    int error_count  = 0;
    int rsp_count    = 0;
    int accept_count = 0;
    int cycle        = 0;
    int fills        = 0;
    int wbs          = 0;
    int accept_edge [$];
    bit alone       [$];

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        error_count++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // idle outputs right after reset
    initial begin
        int waited;
        waited = 0;
        while (arst_n !== 1'b1 && waited < 100) begin
            @(posedge clk);
            waited++;
        end
        @(negedge clk);
        if (arst_n !== 1'b1) report_error("reset never released");
        if (rsp_valid !== 1'b0) report_value("rsp_valid", rsp_valid, 0);
        if (lv2_req_valid !== 1'b0) report_value("lv2_req_valid", lv2_req_valid, 0);
        if (cpu_ready !== 1'b1) report_value("cpu_ready", cpu_ready, 1);
    end

    // ==================================================
    // per-cycle compare, sampled at the falling edge
    // ==================================================
    always @(negedge clk) begin
        int i;
        i = rsp_count;
        if (arst_n && lv2_req_valid && lv2_req_ready) begin
            if (i >= l1_dcache_tb.NUM_ROWS) begin
                report_error("level 2 transfer with no request outstanding");
            end else if (lv2_req_op == lv2_write) begin
                if (fills > 0 || wbs > 0 || !l1_dcache_tb.row_wb[i]) begin
                    report_error("unexpected level 2 writeback");
                end
                if (lv2_addr !== l1_dcache_tb.row_wb_addr[i])
                    report_value("lv2_addr", lv2_addr, l1_dcache_tb.row_wb_addr[i]);
                if (lv2_wdata !== l1_dcache_tb.row_wb_data[i])
                    report_value("lv2_wdata", lv2_wdata, l1_dcache_tb.row_wb_data[i]);
                wbs++;
            end else begin
                if (fills > 0 || !l1_dcache_tb.row_fill[i]) begin
                    report_error("unexpected level 2 fill read");
                end
                if (lv2_addr !== (l1_dcache_tb.row_addr[i] & ~32'h3))
                    report_value("lv2_addr", lv2_addr, l1_dcache_tb.row_addr[i] & ~32'h3);
                fills++;
            end
        end
        if (arst_n && rsp_valid) begin
            if (i >= l1_dcache_tb.NUM_ROWS || accept_edge.size() == 0) begin
                report_error("response with no request outstanding");
            end else begin
                if (l1_dcache_tb.row_op[i] == op_read && rsp_rdata !== l1_dcache_tb.row_rdata[i])
                    report_value("rsp_rdata", rsp_rdata, l1_dcache_tb.row_rdata[i]);
                if (fills != int'(l1_dcache_tb.row_fill[i]))
                    report_value("lv2 fill count", fills, l1_dcache_tb.row_fill[i]);
                if (wbs != int'(l1_dcache_tb.row_wb[i]))
                    report_value("lv2 writeback count", wbs, l1_dcache_tb.row_wb[i]);
                // hit latency only holds when the pipe was empty at accept
                if (alone[0] && !l1_dcache_tb.row_fill[i] && cycle != accept_edge[0] + 2)
                    report_value("rsp_valid latency", cycle - accept_edge[0], 2);
                void'(accept_edge.pop_front());
                void'(alone.pop_front());
            end
            fills = 0;
            wbs   = 0;
            rsp_count++;
        end
        if (arst_n && cpu_valid && cpu_ready) begin
            accept_edge.push_back(cycle + 1);
            alone.push_back(accept_count == rsp_count);
            accept_count++;
        end
    end

endmodule

`default_nettype wire

//--- testbench/lv2_memory_model.sv
// level 2 memory responder with random request back-pressure, words seeded from the address
`timescale 1ns/1ns
`default_nettype none

module lv2_memory_model
    import l1_cache_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    arst_n,
    input  wire logic    lv2_req_valid,
    output logic         lv2_req_ready,
    input  wire lv2_op_e lv2_req_op,
    input  wire logic [ADDR_W-1:0] lv2_addr,
    input  wire data_t   lv2_wdata,
    output logic         lv2_rsp_valid,
    output data_t        lv2_rsp_rdata
);

    localparam logic [31:0] INIT_PATTERN = 32'h5a5a0000;

    // only words written back are stored, the rest come from the pattern
    data_t store [logic [ADDR_W-1:0]];

    logic [31:0] ready_lfsr = 32'h85c8;

    // galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] stepped;
        stepped = state >> 1;
        if (state[0]) begin
            stepped = stepped ^ 32'h8020_0003;
        end
        return stepped;
    endfunction

    function automatic data_t read_word(input logic [ADDR_W-1:0] addr);
        if (store.exists(addr)) begin
            return store[addr];
        end
        return addr ^ INIT_PATTERN;
    endfunction

    // random back-pressure, changed just after each rising edge
    initial begin
        lv2_req_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            lv2_req_ready = ready_lfsr[0];
            ready_lfsr    = lfsr_step(ready_lfsr);
        end
    end

    initial begin
        logic                xfer;
        lv2_op_e             op;
        logic [ADDR_W-1:0]   addr;
        data_t               wdata;
        lv2_rsp_valid = 1'b0;
        lv2_rsp_rdata = '0;
        forever begin
            // handshake sampled away from the clock edge
            @(negedge clk);
            xfer  = arst_n && lv2_req_valid && lv2_req_ready;
            op    = lv2_req_op;
            addr  = lv2_addr;
            wdata = lv2_wdata;
            @(posedge clk);
            if (xfer && op == lv2_write) begin
                store[addr] = wdata;
            end else if (xfer) begin
                // one dead cycle, then the fill word for one cycle
                @(posedge clk);
                #1;
                lv2_rsp_valid = 1'b1;
                lv2_rsp_rdata = read_word(addr);
                @(posedge clk);
                #1;
                lv2_rsp_valid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// testbench clock and reset source, 4 ns period, reset held for 3 cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- design/l1_dcache_top.sv
// L1 data cache top: lookup stage, line controller, tag/state array and data array
`timescale 1ns/1ns
`default_nettype none

module l1_dcache_top
    import l1_cache_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    arst_n,
    // cpu request and response
    input  wire logic    cpu_valid,
    output logic         cpu_ready,
    input  wire cpu_op_e cpu_op,
    input  wire logic [ADDR_W-1:0] cpu_addr,
    input  wire data_t   cpu_wdata,
    output logic         rsp_valid,
    output data_t        rsp_rdata,
    // level 2 request and response
    output logic         lv2_req_valid,
    input  wire logic    lv2_req_ready,
    output lv2_op_e      lv2_req_op,
    output logic [ADDR_W-1:0] lv2_addr,
    output data_t        lv2_wdata,
    input  wire logic    lv2_rsp_valid,
    input  wire data_t   lv2_rsp_rdata
);

    // lookup side of the tag array
    tag_t        lk_tags   [WAYS];
    line_state_e lk_states [WAYS];
    way_t        lk_lru;
    index_t      lk_arr_index;

    // controller side of the tag array
    tag_t        ct_tags   [WAYS];
    line_state_e ct_states [WAYS];
    index_t      ct_index;

    // stage handoff
    logic    lk_valid;
    logic    lk_ready;
    cpu_op_e lk_op;
    tag_t    lk_tag;
    index_t  lk_index;
    data_t   lk_wdata;
    logic    lk_hit;
    way_t    lk_way;

    // array write and read ports
    logic        tag_wr_en;
    way_t        tag_wr_way;
    tag_t        tag_wr_tag;
    line_state_e tag_wr_state;
    logic        lru_en;
    way_t        lru_way;
    logic        data_wr_en;
    way_t        data_wr_way;
    data_t       data_wr_data;
    index_t      data_rd_index;
    way_t        data_rd_way;
    data_t       data_rd_data;

    lookup_stage u_lookup (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_valid (cpu_valid),
        .cpu_ready (cpu_ready),
        .cpu_op    (cpu_op),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .tags      (lk_tags),
        .states    (lk_states),
        .lru       (lk_lru),
        .index     (lk_arr_index),
        .lk_valid  (lk_valid),
        .lk_ready  (lk_ready),
        .lk_op     (lk_op),
        .lk_tag    (lk_tag),
        .lk_index  (lk_index),
        .lk_wdata  (lk_wdata),
        .lk_hit    (lk_hit),
        .lk_way    (lk_way)
    );

    line_ctrl_stage u_ctrl (
        .clk           (clk),
        .arst_n        (arst_n),
        .lk_valid      (lk_valid),
        .lk_ready      (lk_ready),
        .lk_op         (lk_op),
        .lk_tag        (lk_tag),
        .lk_index      (lk_index),
        .lk_wdata      (lk_wdata),
        .lk_hit        (lk_hit),
        .lk_way        (lk_way),
        .victim_tag    (ct_tags),
        .victim_state  (ct_states),
        .ct_index      (ct_index),
        .tag_wr_en     (tag_wr_en),
        .tag_wr_way    (tag_wr_way),
        .tag_wr_tag    (tag_wr_tag),
        .tag_wr_state  (tag_wr_state),
        .lru_en        (lru_en),
        .lru_way       (lru_way),
        .data_wr_en    (data_wr_en),
        .data_wr_way   (data_wr_way),
        .data_wr_data  (data_wr_data),
        .data_rd_index (data_rd_index),
        .data_rd_way   (data_rd_way),
        .data_rd_data  (data_rd_data),
        .rsp_valid     (rsp_valid),
        .rsp_rdata     (rsp_rdata),
        .lv2_req_valid (lv2_req_valid),
        .lv2_req_ready (lv2_req_ready),
        .lv2_req_op    (lv2_req_op),
        .lv2_addr      (lv2_addr),
        .lv2_wdata     (lv2_wdata),
        .lv2_rsp_valid (lv2_rsp_valid),
        .lv2_rsp_rdata (lv2_rsp_rdata)
    );

    tag_state_array u_tags (
        .clk       (clk),
        .arst_n    (arst_n),
        .lk_index  (lk_arr_index),
        .ct_index  (ct_index),
        .wr_en     (tag_wr_en),
        .wr_way    (tag_wr_way),
        .wr_tag    (tag_wr_tag),
        .wr_state  (tag_wr_state),
        .lru_en    (lru_en),
        .lru_way   (lru_way),
        .lk_tags   (lk_tags),
        .lk_states (lk_states),
        .lk_lru    (lk_lru),
        .ct_tags   (ct_tags),
        .ct_states (ct_states)
    );

    // writes always land on the set the controller holds
    data_array u_data (
        .clk      (clk),
        .wr_en    (data_wr_en),
        .wr_index (ct_index),
        .wr_way   (data_wr_way),
        .wr_data  (data_wr_data),
        .rd_index (data_rd_index),
        .rd_way   (data_rd_way),
        .rd_data  (data_rd_data)
    );

endmodule

`default_nettype wire

//--- design/line_ctrl_stage.sv
// line controller FSM: hit completion, victim writeback, line fill and install
`timescale 1ns/1ns
`default_nettype none

module line_ctrl_stage
    import l1_cache_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        arst_n,
    // from the lookup stage
    input  wire logic        lk_valid,
    output logic             lk_ready,
    input  wire cpu_op_e     lk_op,
    input  wire tag_t        lk_tag,
    input  wire index_t      lk_index,
    input  wire data_t       lk_wdata,
    input  wire logic        lk_hit,
    input  wire way_t        lk_way,
    // tag array, controller port
    input  wire tag_t        victim_tag   [WAYS],
    input  wire line_state_e victim_state [WAYS],
    output index_t           ct_index,
    output logic             tag_wr_en,
    output way_t             tag_wr_way,
    output tag_t             tag_wr_tag,
    output line_state_e      tag_wr_state,
    output logic             lru_en,
    output way_t             lru_way,
    // data array
    output logic             data_wr_en,
    output way_t             data_wr_way,
    output data_t            data_wr_data,
    output index_t           data_rd_index,
    output way_t             data_rd_way,
    input  wire data_t       data_rd_data,
    // cpu response
    output logic             rsp_valid,
    output data_t            rsp_rdata,
    // level 2
    output logic             lv2_req_valid,
    input  wire logic        lv2_req_ready,
    output lv2_op_e          lv2_req_op,
    output logic [ADDR_W-1:0] lv2_addr,
    output data_t            lv2_wdata,
    input  wire logic        lv2_rsp_valid,
    input  wire data_t       lv2_rsp_rdata
);

    typedef enum logic [2:0] {
        st_idle,
        st_writeback,
        st_fill_req,
        st_fill_wait,
        st_update,
        st_respond
    } ctrl_state_e;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    // request held for the whole transaction
    cpu_op_e op_q;
    tag_t    tag_q;
    index_t  index_q;
    data_t   wdata_q;
    logic    hit_q;
    way_t    way_q;
    data_t   fill_q;

    logic    line_write;
    tag_t    req_tag;

    // ==================================================
    // state machine
    // ==================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (lk_valid) begin
                    if (lk_hit) begin
                        state_d = st_update;
                    end else if (victim_state[lk_way] == line_modified) begin
                        state_d = st_writeback;
                    end else begin
                        state_d = st_fill_req;
                    end
                end
            end
            st_writeback: begin
                if (lv2_req_ready) begin
                    state_d = st_fill_req;
                end
            end
            st_fill_req: begin
                if (lv2_req_ready) begin
                    state_d = st_fill_wait;
                end
            end
            st_fill_wait: begin
                if (lv2_rsp_valid) begin
                    state_d = st_update;
                end
            end
            st_update:  state_d = st_respond;
            st_respond: state_d = st_idle;
            default:    state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle && lk_valid) begin
            op_q    <= lk_op;
            tag_q   <= lk_tag;
            index_q <= lk_index;
            wdata_q <= lk_wdata;
            hit_q   <= lk_hit;
            way_q   <= lk_way;
        end
        if (state_q == st_fill_wait && lv2_rsp_valid) begin
            fill_q <= lv2_rsp_rdata;
        end
    end

    assign lk_ready = (state_q == st_idle);

    // victim state is checked at the incoming index while idle
    assign ct_index = (state_q == st_idle) ? lk_index : index_q;

    // ==================================================
    // array updates
    // ==================================================
    // read hits only touch LRU
    assign line_write = (state_q == st_update) && (op_q == op_write || !hit_q);

    assign tag_wr_en    = line_write;
    assign tag_wr_way   = way_q;
    assign tag_wr_tag   = tag_q;
    assign tag_wr_state = (op_q == op_write) ? line_modified : line_exclusive;
    assign lru_en       = (state_q == st_update);
    assign lru_way      = way_q;

    // write data replaces the filled word
    assign data_wr_en   = line_write;
    assign data_wr_way  = way_q;
    assign data_wr_data = (op_q == op_write) ? wdata_q : fill_q;

    assign data_rd_index = index_q;
    assign data_rd_way   = way_q;

    // array already holds the final word by respond
    assign rsp_valid = (state_q == st_respond);
    assign rsp_rdata = data_rd_data;

    // ==================================================
    // level 2 request
    // ==================================================
    assign req_tag       = (state_q == st_writeback) ? victim_tag[way_q] : tag_q;
    assign lv2_req_valid = (state_q == st_writeback) || (state_q == st_fill_req);
    assign lv2_req_op    = (state_q == st_writeback) ? lv2_write : lv2_read;
    assign lv2_addr      = {req_tag, index_q, {OFFSET_W{1'b0}}};
    assign lv2_wdata     = data_rd_data;

endmodule

`default_nettype wire

//--- design/lookup_stage.sv
// lookup stage: request register, tag compare, hit way and victim way select
`timescale 1ns/1ns
`default_nettype none

module lookup_stage
    import l1_cache_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic        cpu_valid,
    output logic             cpu_ready,
    input  wire cpu_op_e     cpu_op,
    input  wire logic [ADDR_W-1:0] cpu_addr,
    input  wire data_t       cpu_wdata,
    input  wire tag_t        tags   [WAYS],
    input  wire line_state_e states [WAYS],
    input  wire way_t        lru,
    output index_t           index,
    output logic             lk_valid,
    input  wire logic        lk_ready,
    output cpu_op_e          lk_op,
    output tag_t             lk_tag,
    output index_t           lk_index,
    output data_t            lk_wdata,
    output logic             lk_hit,
    output way_t             lk_way
);

    logic            full_q;
    cpu_op_e         op_q;
    tag_t            tag_q;
    index_t          index_q;
    data_t           wdata_q;
    logic [WAYS-1:0] way_hit;
    logic            accept;

    // free slot, or the held item leaves this cycle
    assign cpu_ready = !full_q || lk_ready;
    assign accept    = cpu_valid && cpu_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (lk_ready) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= cpu_op;
            tag_q   <= cpu_addr[ADDR_W-1 -: TAG_W];
            index_q <= cpu_addr[OFFSET_W +: INDEX_W];
            wdata_q <= cpu_wdata;
        end
    end

    // ==================================================
    // compare against the array as it is now
    // ==================================================
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = (states[w] != line_invalid) && (tags[w] == tag_q);
        end
    end

    // hit way first, then lowest invalid way, then the way not used last
    always_comb begin
        lk_hit = |way_hit;
        lk_way = ~lru;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (states[w] == line_invalid) begin
                lk_way = way_t'(w);
            end
        end
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (way_hit[w]) begin
                lk_way = way_t'(w);
            end
        end
    end

    assign index    = index_q;
    assign lk_valid = full_q;
    assign lk_op    = op_q;
    assign lk_tag   = tag_q;
    assign lk_index = index_q;
    assign lk_wdata = wdata_q;

endmodule

`default_nettype wire

//--- design/data_array.sv
// data word storage, one write port and one asynchronous read port
`timescale 1ns/1ns
`default_nettype none

module data_array
    import l1_cache_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   wr_en,
    input  wire index_t wr_index,
    input  wire way_t   wr_way,
    input  wire data_t  wr_data,
    input  wire index_t rd_index,
    input  wire way_t   rd_way,
    output data_t       rd_data
);

    // one word per line
    data_t mem [WAYS][SETS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_way][wr_index] <= wr_data;
        end
    end

    // hit read or victim word, never both at once
    assign rd_data = mem[rd_way][rd_index];

endmodule

`default_nettype wire

//--- design/tag_state_array.sv
// tag, line state and LRU storage with a lookup read port and a controller port
`timescale 1ns/1ns
`default_nettype none

module tag_state_array
    import l1_cache_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire index_t      lk_index,
    input  wire index_t      ct_index,
    input  wire logic        wr_en,
    input  wire way_t        wr_way,
    input  wire tag_t        wr_tag,
    input  wire line_state_e wr_state,
    input  wire logic        lru_en,
    input  wire way_t        lru_way,
    output tag_t             lk_tags   [WAYS],
    output line_state_e      lk_states [WAYS],
    output way_t             lk_lru,
    output tag_t             ct_tags   [WAYS],
    output line_state_e      ct_states [WAYS]
);

    tag_t        tags   [WAYS][SETS];
    line_state_e states [WAYS][SETS];
    // holds the way used last in each set
    way_t        lru    [SETS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags[wr_way][ct_index] <= wr_tag;
        end
    end

    // all lines start invalid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < SETS; s++) begin
                lru[s] <= 1'b0;
                for (int w = 0; w < WAYS; w++) begin
                    states[w][s] <= line_invalid;
                end
            end
        end else begin
            if (wr_en) begin
                states[wr_way][ct_index] <= wr_state;
            end
            if (lru_en) begin
                lru[ct_index] <= lru_way;
            end
        end
    end

    // asynchronous reads on both ports
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            lk_tags[w]   = tags[w][lk_index];
            lk_states[w] = states[w][lk_index];
            ct_tags[w]   = tags[w][ct_index];
            ct_states[w] = states[w][ct_index];
        end
    end

    assign lk_lru = lru[lk_index];

endmodule

`default_nettype wire

//--- common/l1_cache_pkg.sv
// cache geometry, address field widths and the shared cache enums
`default_nettype none

package l1_cache_pkg;

    // ==================================================
    // address split and geometry
    // ==================================================
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int OFFSET_W = 2;
    localparam int INDEX_W  = 4;
    localparam int SETS     = 16;
    localparam int WAYS     = 2;
    // tag is whatever is left above index and byte offset
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic               way_t;
    typedef logic [DATA_W-1:0]  data_t;

    // ==================================================
    // enums
    // ==================================================
    // MESI without shared, same codes as the four-state version
    typedef enum logic [1:0] {
        line_invalid   = 2'b00,
        line_exclusive = 2'b10,
        line_modified  = 2'b11
    } line_state_e;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } cpu_op_e;

    typedef enum logic {
        lv2_read  = 1'b0,
        lv2_write = 1'b1
    } lv2_op_e;

endpackage

`default_nettype wire
